// ==== build.f ====
src/hdc_pkg.sv
src/hdc_inst_decoder.sv
src/hdc_item_memory.sv
src/hdc_exec_unit.sv
src/hdc_core.sv
sim/hdc_core_tb.sv

// ==== Bender.yml ====
package:
  name: hdc_core

dependencies:

sources:
  # design sources in compile order
  - files:
      - src/hdc_pkg.sv
      - src/hdc_inst_decoder.sv
      - src/hdc_item_memory.sv
      - src/hdc_exec_unit.sv
      - src/hdc_core.sv

  # testbench, top module hdc_core_tb
  - target: any(test, simulation)
    files:
      - sim/hdc_core_tb.sv

// ==== sim/hdc_core_tb.sv ====
module hdc_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hdc_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  get_v;
    logic [15:0]           get_d;
    logic                  exec;
    logic                  load_en;
    logic [ADDR_WIDTH-1:0] load_addr;
    hv_t                   load_data;
    logic                  store;
    hv_t                   core_result;
    logic                  last;

    // shadow model of memory and thread registers
    hv_t model_mem [MEM_DEPTH];
    hv_t model_a [THREADS];
    hv_t model_b [THREADS];
    hv_t perm_src;
    int  perm_amt;
    int  cur_thread;

    // expected result delayed to line up with the store pulse
    hv_t  exp_result;
    hv_t  exp_d1;
    hv_t  exp_d2;
    logic store_insn;
    logic last_insn;

    int error_count;
    int pass_count;
    int fail_count;
    int test_start_errs;
    int stores_expected;
    int store_seen;
    int timeout_cycles;

    hdc_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .get_v       (get_v),
        .get_d       (get_d),
        .exec        (exec),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // opcode patterns as the host encodes them
    assign store_insn = get_v && (get_d[15:11] == 5'b00001);
    assign last_insn  = get_v && (get_d[15:10] == 6'b000001);

    always @(posedge clk) begin
        exp_d1 <= exp_result;
        exp_d2 <= exp_d1;
    end

    always @(negedge clk) begin
        if (store === 1'b1) begin
            store_seen <= store_seen + 1;
        end
    end

    a_store_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $past(store_insn, 2) && $past(exec) && $past(run) |-> store === 1'b1
    ) else begin
        error_count++;
        $display("Mismatch at %0t: store expected 1, got %b", $time, $sampled(store));
    end

    a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
        $past(store_insn, 2) && $past(exec) && $past(run) |-> core_result === exp_d2
    ) else begin
        error_count++;
        $display("Mismatch at %0t: core_result expected %h, got %h",
                 $time, $sampled(exp_d2), $sampled(core_result));
    end

    // result bus is zero outside the store pulse
    a_result_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !store |-> core_result === '0
    ) else begin
        error_count++;
        $display("Mismatch at %0t: core_result expected 0, got %h",
                 $time, $sampled(core_result));
    end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !store && !last && core_result === '0
    ) else begin
        error_count++;
        $display("[%0t] outputs were not cleared by reset", $time);
    end

    a_run_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !run |=> !store && !last && core_result === '0
    ) else begin
        error_count++;
        $display("[%0t] store, last or core_result active while run was low", $time);
    end

    a_last_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $past(last_insn, 2) && $past(exec) && $past(run) |-> last === 1'b1
    ) else begin
        error_count++;
        $display("Mismatch at %0t: last expected 1, got %b", $time, $sampled(last));
    end

    a_last_hold: assert property (@(posedge clk) disable iff (!rst_n)
        last && exec && run |=> last
    ) else begin
        error_count++;
        $display("Mismatch at %0t: last expected 1, got %b", $time, $sampled(last));
    end

    a_last_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !exec |=> !last
    ) else begin
        error_count++;
        $display("Mismatch at %0t: last expected 0, got %b", $time, $sampled(last));
    end

    function automatic hv_t rotl(input hv_t v, input int k);
        if (k == 0) begin
            return v;
        end
        return (v << k) | (v >> (HV_WIDTH - k));
    endfunction

    function automatic hv_t rand_hv();
        return {$urandom, $urandom};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < THREADS; i++) begin
            model_a[i] = '0;
            model_b[i] = '0;
        end
        perm_src = '0;
        perm_amt = 0;
    endtask

    // thread counter starts at 0 on the first word of a burst
    task automatic advance_thread();
        cur_thread = (cur_thread + 1) % THREADS;
    endtask

    task automatic put_word(input logic [15:0] w);
        get_v = 1'b1;
        get_d = w;
        @(negedge clk);
    endtask

    task automatic end_burst();
        get_v      = 1'b0;
        get_d      = '0;
        cur_thread = -1;
        @(negedge clk);
    endtask

    task automatic host_load(input int addr, input hv_t data);
        model_mem[addr] = data;
        load_en   = 1'b1;
        load_addr = ADDR_WIDTH'(addr);
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic do_load(input int addr);
        advance_thread();
        model_b[cur_thread] = model_mem[addr];
        put_word(16'hC000 | 16'(addr));
    endtask

    task automatic do_perm_set(input int k);
        advance_thread();
        perm_src = model_b[cur_thread];
        perm_amt = k;
        put_word(16'h4000 | 16'(k));
    endtask

    task automatic do_perm_get();
        advance_thread();
        model_b[cur_thread] = rotl(perm_src, perm_amt);
        put_word(16'h2000);
    endtask

    task automatic do_xor();
        advance_thread();
        model_b[cur_thread] = model_a[cur_thread] ^ model_b[cur_thread];
        put_word(16'h1000);
    endtask

    task automatic do_move();
        advance_thread();
        model_a[cur_thread] = model_b[cur_thread];
        put_word(16'h0200);
    endtask

    task automatic do_store();
        advance_thread();
        exp_result = model_b[cur_thread];
        stores_expected++;
        put_word(16'h0800);
    endtask

    task automatic do_nop();
        advance_thread();
        put_word(16'h0000);
    endtask

    task automatic do_write_back(input int addr);
        advance_thread();
        model_mem[addr] = model_b[cur_thread];
        put_word(16'hA000 | 16'(addr));
    endtask

    task automatic wait_stores();
        int n;
        n = 0;
        while (store_seen < stores_expected && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (store_seen < stores_expected) begin
            error_count++;
            $display("[%0t] timeout: saw %0d store pulses, expected %0d",
                     $time, store_seen, stores_expected);
            stores_expected = store_seen;
        end
    endtask

    task automatic wait_last(input logic level);
        int n;
        n = 0;
        while (last !== level && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (last !== level) begin
            error_count++;
            $display("[%0t] timeout: last never went to %0b", $time, level);
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errs) begin
            pass_count++;
            $display("[%0t] test %s: passed", $time, name);
        end else begin
            fail_count++;
            $display("[%0t] test %s: failed with %0d errors",
                     $time, name, error_count - test_start_errs);
        end
        test_start_errs = error_count;
    endtask

    initial begin
        hv_t va;
        int  addr;
        int  addr2;
        int  base;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(45));
        rst_n     = 1'b0;
        run       = 1'b0;
        get_v     = 1'b0;
        get_d     = '0;
        exec      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        exp_result      = '0;
        error_count     = 0;
        pass_count      = 0;
        fail_count      = 0;
        test_start_errs = 0;
        stores_expected = 0;
        store_seen      = 0;
        timeout_cycles  = 32;
        cur_thread      = -1;
        clear_model();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        run   = 1'b1;
        exec  = 1'b1;
        @(negedge clk);

        // registers start at zero and are cleared again when run drops
        do_store();
        end_burst();
        wait_stores();
        va   = rand_hv();
        addr = $urandom_range(0, MEM_DEPTH - 1);
        host_load(addr, va);
        do_load(addr);
        end_burst();
        run = 1'b0;
        clear_model();
        advance_thread();
        put_word(16'h0800);
        advance_thread();
        put_word(16'h0400);
        end_burst();
        repeat (2) @(negedge clk);
        run = 1'b1;
        do_store();
        end_burst();
        wait_stores();
        end_test("reset_and_idle");

        va   = rand_hv();
        addr = $urandom_range(0, MEM_DEPTH - 1);
        host_load(addr, va);
        do_load(addr);
        end_burst();
        do_store();
        end_burst();
        wait_stores();
        end_test("load_store");

        addr  = $urandom_range(0, 255);
        addr2 = addr + 256;
        host_load(addr, rand_hv());
        host_load(addr2, rand_hv());
        do_load(addr);
        end_burst();
        do_move();
        end_burst();
        do_load(addr2);
        end_burst();
        do_xor();
        end_burst();
        do_store();
        end_burst();
        wait_stores();
        end_test("xor_move");

        for (int i = 0; i < 3; i++) begin
            addr = $urandom_range(0, MEM_DEPTH - 1);
            host_load(addr, rand_hv());
            do_load(addr);
            end_burst();
            do_perm_set($urandom_range(1, HV_WIDTH - 1));
            end_burst();
            do_perm_get();
            end_burst();
            do_store();
            end_burst();
            wait_stores();
        end
        end_test("permute");

        // one load per thread then one store per thread in one burst
        base = $urandom_range(0, 400);
        for (int i = 0; i < THREADS; i++) begin
            host_load(base + i * 13, rand_hv());
        end
        for (int i = 0; i < THREADS; i++) begin
            do_load(base + i * 13);
        end
        for (int i = 0; i < THREADS; i++) begin
            do_store();
        end
        end_burst();
        wait_stores();
        end_test("thread_burst");

        // write-back from thread 1 and read back through thread 0
        addr = base + 100;
        do_nop();
        do_write_back(addr);
        end_burst();
        do_load(addr);
        end_burst();
        do_store();
        end_burst();
        wait_stores();
        // load right behind a write-back of the same address
        addr2 = base + 101;
        do_nop();
        do_nop();
        do_write_back(addr2);
        do_load(addr2);
        end_burst();
        for (int i = 0; i < 3; i++) begin
            do_nop();
        end
        do_store();
        end_burst();
        wait_stores();
        end_test("write_back");

        do_nop();
        end_burst();
        put_word(16'h0400);
        end_burst();
        wait_last(1'b1);
        repeat (3) @(negedge clk);
        exec = 1'b0;
        wait_last(1'b0);
        exec = 1'b1;
        repeat (4) @(negedge clk);
        end_test("last");

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/hdc_core.sv ====
module hdc_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           get_v,
    input  logic [15:0]                    get_d,
    input  logic                           exec,
    input  logic                           load_en,
    input  logic [hdc_pkg::ADDR_WIDTH-1:0] load_addr,
    input  hdc_pkg::hv_t                   load_data,
    output logic                           store,
    output hdc_pkg::hv_t                   core_result,
    output logic                           last
);
    import hdc_pkg::*;

    hdc_inst_t   inst;
    hdc_issue_t  issue;
    hdc_wr_req_t wb_req;
    hdc_wr_req_t load_req;
    hv_t         rd_data;
    hv_t         wb_data;

    assign inst     = hdc_inst_t'(get_d);
    assign load_req = '{en: load_en, addr: load_addr, data: load_data};

    hdc_inst_decoder decoder0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .get_v  (get_v),
        .get_d  (inst),
        .issue  (issue),
        .wb_req (wb_req)
    );

    // address taken straight off the instruction bus every cycle
    hdc_item_memory memory0 (
        .clk      (clk),
        .wb_req   (wb_req),
        .wb_data  (wb_data),
        .load_req (load_req),
        .rd_addr  (get_d[ADDR_WIDTH-1:0]),
        .rd_data  (rd_data)
    );

    hdc_exec_unit exec0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .exec        (exec),
        .issue       (issue),
        .rd_data     (rd_data),
        .wb_data     (wb_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

endmodule

// ==== src/hdc_exec_unit.sv ====
module hdc_exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic                exec,
    input  hdc_pkg::hdc_issue_t issue,
    input  hdc_pkg::hv_t        rd_data,
    output hdc_pkg::hv_t        wb_data,
    output logic                store,
    output hdc_pkg::hv_t        core_result,
    output logic                last
);
    import hdc_pkg::*;

    // per-thread working and operand registers
    hv_t                   reg_a [THREADS];
    hv_t                   reg_b [THREADS];

    hv_t                   cur_a;
    hv_t                   cur_b;
    logic                  thread_ok;
    logic                  clear;

    hv_t                   perm_src;
    logic [ROT_WIDTH-1:0]  perm_amt;
    logic [2*HV_WIDTH-1:0] perm_dbl;
    hv_t                   perm_rot;

    hv_t                   buff;

    assign clear     = !rst_n || !run;
    assign thread_ok = (issue.thread < THREADS);

    // selected thread, zero while idle
    always_comb begin
        cur_a = '0;
        cur_b = '0;
        if (thread_ok) begin
            cur_a = reg_a[issue.thread];
            cur_b = reg_b[issue.thread];
        end
    end

    assign wb_data = cur_b;

    // rotate left, top half of the doubled word
    assign perm_dbl = {perm_src, perm_src} << perm_amt;
    assign perm_rot = perm_dbl[2*HV_WIDTH-1 -: HV_WIDTH];

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < THREADS; i++) begin
                reg_a[i] <= '0;
                reg_b[i] <= '0;
            end
        end else if (exec && thread_ok) begin
            case (issue.op)
                OP_LOAD: begin
                    reg_b[issue.thread] <= rd_data;
                end
                OP_PERM_GET: begin
                    reg_b[issue.thread] <= perm_rot;
                end
                OP_XOR: begin
                    reg_b[issue.thread] <= cur_a ^ cur_b;
                end
                OP_MOVE: begin
                    reg_a[issue.thread] <= cur_b;
                end
                default: begin
                end
            endcase
        end
    end

    // store pulse, sticky last and the captured permute source
    always_ff @(posedge clk) begin
        if (clear) begin
            store    <= 1'b0;
            last     <= 1'b0;
            perm_src <= '0;
            perm_amt <= '0;
        end else if (!exec) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= (issue.op == OP_STORE);
            if (issue.op == OP_LAST) begin
                last <= 1'b1;
            end
            // shared between threads, held until the next perm-set
            if (issue.op == OP_PERM_SET) begin
                perm_src <= cur_b;
                perm_amt <= issue.rot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec && (issue.op == OP_STORE)) begin
            buff <= cur_b;
        end
    end

    // result bus only carries data during the store pulse
    assign core_result = store ? buff : '0;

    a_quiet_when_stopped: assert property (
        @(posedge clk) disable iff (!rst_n)
        !run |=> !store && !last
    );

    // decoder only issues real operations to existing threads
    a_thread_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.op != OP_NOP |-> issue.thread < THREADS
    );

endmodule

// ==== src/hdc_item_memory.sv ====
module hdc_item_memory (
    input  logic                          clk,
    input  hdc_pkg::hdc_wr_req_t          wb_req,
    input  hdc_pkg::hv_t                  wb_data,
    input  hdc_pkg::hdc_wr_req_t          load_req,
    input  logic [hdc_pkg::ADDR_WIDTH-1:0] rd_addr,
    output hdc_pkg::hv_t                  rd_data
);
    import hdc_pkg::*;

    hv_t         mem [MEM_DEPTH];
    hdc_wr_req_t wb_full;
    hdc_wr_req_t wr_req;

    // write-back carries the current thread's reg_b
    always_comb begin
        wb_full      = wb_req;
        wb_full.data = wb_data;
    end

    // single write port, write-back wins over the host load
    assign wr_req = wb_full.en ? wb_full : load_req;

    always_ff @(posedge clk) begin
        if (wr_req.en) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // write-first read, so a load right after a write-back sees new data
    always_ff @(posedge clk) begin
        if (wr_req.en && (wr_req.addr == rd_addr)) begin
            rd_data <= wr_req.data;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

    // host must not load the address being written back
    a_no_addr_clash: assert property (
        @(posedge clk)
        wb_req.en && load_req.en |-> wb_req.addr != load_req.addr
    ) else $warning("load port write to 0x%0h dropped by write-back", load_req.addr);

endmodule

// ==== src/hdc_inst_decoder.sv ====
module hdc_inst_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 get_v,
    input  hdc_pkg::hdc_inst_t   get_d,
    output hdc_pkg::hdc_issue_t  issue,
    output hdc_pkg::hdc_wr_req_t wb_req
);
    import hdc_pkg::*;

    hdc_op_e               dec_op;
    logic                  is_wb;
    thread_idx_t           next_thread;

    hdc_op_e               op_q;
    thread_idx_t           thread_q;
    logic [ROT_WIDTH-1:0]  rot_q;
    logic                  wb_en_q;
    logic [ADDR_WIDTH-1:0] wb_addr_q;

    // wb.item is recognised before any opcode flag
    assign is_wb = get_d.wb.mark_hi & get_d.wb.mark_lo;

    // priority order load, perm-set, perm-get, xor, store, last, move
    always_comb begin
        dec_op = OP_NOP;
        if (get_d.op.need_addr) begin
            if (get_d.op.flags[FLAG_LOAD_PSET]) begin
                dec_op = OP_LOAD;
            end
        end else if (get_d.op.flags[FLAG_LOAD_PSET]) begin
            dec_op = OP_PERM_SET;
        end else if (get_d.op.flags[FLAG_PERM_GET]) begin
            dec_op = OP_PERM_GET;
        end else if (get_d.op.flags[FLAG_XOR]) begin
            dec_op = OP_XOR;
        end else if (get_d.op.flags[FLAG_STORE]) begin
            dec_op = OP_STORE;
        end else if (get_d.op.flags[FLAG_LAST]) begin
            dec_op = OP_LAST;
        end else if (get_d.op.flags[FLAG_MOVE]) begin
            dec_op = OP_MOVE;
        end
        // bit 8 alone stays a nop
    end

    // round robin over the threads, idle value rolls over to 0
    assign next_thread = (thread_q == THREAD_IDX_WIDTH'(THREADS - 1)) ? '0 : thread_q + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n || !get_v) begin
            op_q     <= OP_NOP;
            thread_q <= THREAD_IDLE;
            wb_en_q  <= 1'b0;
        end else begin
            op_q     <= is_wb ? OP_NOP : dec_op;
            thread_q <= next_thread;
            wb_en_q  <= is_wb;
        end
    end

    // operand fields, only meaningful alongside op_q / wb_en_q
    always_ff @(posedge clk) begin
        rot_q     <= get_d.op.operand[ROT_WIDTH-1:0];
        wb_addr_q <= get_d.wb.addr;
    end

    assign issue = '{op: op_q, rot: rot_q, thread: thread_q};

    // data is filled in by the memory from the execution unit
    assign wb_req = '{en: wb_en_q, addr: wb_addr_q, data: '0};

    // back-to-back write-backs need back-to-back strobes
    a_wb_needs_strobes: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_req.en && $past(wb_req.en) |-> $past(get_v, 1) && $past(get_v, 2)
    );

endmodule

// ==== src/hdc_pkg.sv ====
package hdc_pkg;

    // datapath sizes
    localparam int HV_WIDTH         = 64;
    localparam int MEM_DEPTH        = 512;
    localparam int ADDR_WIDTH       = 9;
    localparam int THREADS          = 5;
    localparam int THREAD_IDX_WIDTH = 3;
    localparam int ROT_WIDTH        = 6;

    // flag positions in the 7-bit opcode field (word bits 14..8)
    // load when the address flag is set, perm-set otherwise
    localparam int FLAG_LOAD_PSET = 6;
    localparam int FLAG_PERM_GET  = 5;
    localparam int FLAG_XOR       = 4;
    localparam int FLAG_STORE     = 3;
    localparam int FLAG_LAST      = 2;
    localparam int FLAG_MOVE      = 1;

    typedef logic [HV_WIDTH-1:0]         hv_t;
    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // thread index while no instruction is flowing
    // wraps to thread 0 on the next strobe
    localparam thread_idx_t THREAD_IDLE = '1;

    // opcode view of an instruction word
    // operand bits 9 and 8 share wires with the move and sign flags,
    // so only the low byte is a field of its own
    typedef struct packed {
        logic       need_addr;
        logic [6:0] flags;
        logic [7:0] operand;
    } hdc_op_word_t;

    // write-back view, marked by bits 15 and 13
    typedef struct packed {
        logic                  mark_hi;
        logic                  rsvd_hi;
        logic                  mark_lo;
        logic [3:0]            rsvd_lo;
        logic [ADDR_WIDTH-1:0] addr;
    } hdc_wb_word_t;

    typedef union packed {
        hdc_op_word_t op;
        hdc_wb_word_t wb;
    } hdc_inst_t;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_LOAD,
        OP_PERM_SET,
        OP_PERM_GET,
        OP_XOR,
        OP_STORE,
        OP_LAST,
        OP_MOVE
    } hdc_op_e;

    // one decoded operation toward the execution unit
    typedef struct packed {
        hdc_op_e              op;
        logic [ROT_WIDTH-1:0] rot;
        thread_idx_t          thread;
    } hdc_issue_t;

    // memory write request
    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        hv_t                   data;
    } hdc_wr_req_t;

endpackage
